// ==== source/mdu_pkg.sv ====
// Multiply/divide unit definitions

package mdu_pkg;

	// Register and word widths.
	localparam int XLEN  = 64;
	localparam int HXLEN = XLEN / 2;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      tag_t;  // Destination register index.

	// Word flag followed by funct3.
	typedef enum logic [3:0] {
		OP_MUL    = 4'b0000,
		OP_MULH   = 4'b0001,
		OP_MULHSU = 4'b0010,
		OP_MULHU  = 4'b0011,
		OP_DIV    = 4'b0100,
		OP_DIVU   = 4'b0101,
		OP_REM    = 4'b0110,
		OP_REMU   = 4'b0111,
		OP_MULW   = 4'b1000,
		OP_DIVW   = 4'b1100,
		OP_DIVUW  = 4'b1101,
		OP_REMW   = 4'b1110,
		OP_REMUW  = 4'b1111
	} mdu_op_e;

	typedef enum logic [1:0] {
		MUL_LOW     = 2'b00,
		MUL_HIGH_SS = 2'b01,
		MUL_HIGH_SU = 2'b10,
		MUL_HIGH_UU = 2'b11
	} mul_op_e;

	// Bit 1 picks the remainder, bit 0 marks unsigned.
	typedef enum logic [1:0] {
		DIV_Q_S = 2'b00,
		DIV_Q_U = 2'b01,
		DIV_R_S = 2'b10,
		DIV_R_U = 2'b11
	} div_op_e;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		RUN  = 2'b01,
		FIX  = 2'b10,
		DONE = 2'b11
	} div_state_e;

	// Issue bus.
	typedef struct packed {
		xlen_t      src1;
		xlen_t      src2;
		logic [2:0] funct3;
		logic       word;
		tag_t       tag;
	} mdu_req_t;

	// Request as seen by one execution unit.
	typedef struct packed {
		xlen_t      src1;
		xlen_t      src2;
		logic       word;
		tag_t       tag;
		logic [1:0] op;  // mul_op_e or div_op_e.
	} unit_req_t;

	// Result bus.
	typedef struct packed {
		tag_t  tag;
		xlen_t data;
	} wb_t;

endpackage

// ==== source/mdu_decode.sv ====
// Request steering
`timescale 1ns/100ps

module mdu_decode (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue,
	input  mdu_pkg::mdu_req_t  req,
	input  logic               mul_ready,
	input  logic               div_ready,
	output logic               mul_issue,
	output logic               div_issue,
	output mdu_pkg::unit_req_t unit_req
);

	localparam int HX = mdu_pkg::HXLEN;

	mdu_pkg::mdu_op_e op;
	logic             is_div;
	logic [1:0]       unit_op;
	logic             ext1;
	logic             ext2;

	assign op = mdu_pkg::mdu_op_e'({req.word, req.funct3});

	always_comb begin
		is_div  = 1'b1;
		unit_op = mdu_pkg::MUL_LOW;
		case (op)
			mdu_pkg::OP_MULH:                   unit_op = mdu_pkg::MUL_HIGH_SS;
			mdu_pkg::OP_MULHSU:                 unit_op = mdu_pkg::MUL_HIGH_SU;
			mdu_pkg::OP_MULHU:                  unit_op = mdu_pkg::MUL_HIGH_UU;
			mdu_pkg::OP_DIV, mdu_pkg::OP_DIVW:   unit_op = mdu_pkg::DIV_Q_S;
			mdu_pkg::OP_DIVU, mdu_pkg::OP_DIVUW: unit_op = mdu_pkg::DIV_Q_U;
			mdu_pkg::OP_REM, mdu_pkg::OP_REMW:   unit_op = mdu_pkg::DIV_R_S;
			mdu_pkg::OP_REMU, mdu_pkg::OP_REMUW: unit_op = mdu_pkg::DIV_R_U;
			default:                            is_div = 1'b0;
		endcase
		if (op == mdu_pkg::OP_MULH || op == mdu_pkg::OP_MULHSU || op == mdu_pkg::OP_MULHU)
			is_div = 1'b0;
	end

	// Word division extends the low halves by the op's signedness.
	assign ext1 = !unit_op[0] && req.src1[HX-1];
	assign ext2 = !unit_op[0] && req.src2[HX-1];

	always_comb begin
		unit_req.src1 = req.src1;
		unit_req.src2 = req.src2;
		if (is_div && req.word) begin
			unit_req.src1 = {{HX{ext1}}, req.src1[HX-1:0]};
			unit_req.src2 = {{HX{ext2}}, req.src2[HX-1:0]};
		end
		unit_req.word = req.word;
		unit_req.tag  = req.tag;
		unit_req.op   = unit_op;
	end

	assign mul_issue = issue && !is_div && mul_ready;
	assign div_issue = issue && is_div && div_ready;  // Issues to a busy unit are dropped.

	a_issue_accepted: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> (is_div ? div_ready : mul_ready));

	a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!(mul_issue && div_issue));

endmodule

// ==== source/mul_unit.sv ====
// Pipelined multiplier
`timescale 1ns/100ps

module mul_unit #(
	parameter int XLEN = mdu_pkg::XLEN
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue,
	input  mdu_pkg::unit_req_t req,
	input  logic               stall,
	output logic               done,
	output mdu_pkg::wb_t       result
);

	localparam int PW = 2 * XLEN;
	localparam int HX = mdu_pkg::HXLEN;

	mdu_pkg::mul_op_e req_op;
	logic             sgn_a;
	logic             sgn_b;

	logic             s1_valid;
	logic [PW-1:0]    s1_a;
	logic [PW-1:0]    s1_b;
	mdu_pkg::mul_op_e s1_op;
	logic             s1_word;
	mdu_pkg::tag_t    s1_tag;
	logic [PW-1:0]    product;

	logic             s2_valid;
	logic [PW-1:0]    s2_prod;
	mdu_pkg::mul_op_e s2_op;
	logic             s2_word;
	mdu_pkg::tag_t    s2_tag;

	assign req_op = mdu_pkg::mul_op_e'(req.op);

	// Only MULHU treats src1 as unsigned.
	assign sgn_a = (req_op != mdu_pkg::MUL_HIGH_UU) && req.src1[XLEN-1];
	assign sgn_b = (req_op == mdu_pkg::MUL_LOW || req_op == mdu_pkg::MUL_HIGH_SS)
		&& req.src2[XLEN-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (!stall) begin
			s1_valid <= issue;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if (issue) begin
				s1_a    <= {{XLEN{sgn_a}}, req.src1};
				s1_b    <= {{XLEN{sgn_b}}, req.src2};
				s1_op   <= req_op;
				s1_word <= req.word;
				s1_tag  <= req.tag;
			end
			if (s1_valid) begin
				s2_prod <= product;
				s2_op   <= s1_op;
				s2_word <= s1_word;
				s2_tag  <= s1_tag;
			end
		end
	end

	assign product = s1_a * s1_b;  // Low 2*XLEN bits are exact for every variant.

	always_comb begin
		result.tag = s2_tag;
		if (s2_op == mdu_pkg::MUL_LOW)
			result.data = s2_word ? {{HX{s2_prod[HX-1]}}, s2_prod[HX-1:0]} : s2_prod[XLEN-1:0];
		else
			result.data = s2_prod[PW-1:XLEN];
	end

	assign done = s2_valid;

	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall && s2_valid |=> s2_valid);

endmodule

// ==== source/div_unit.sv ====
// Iterative divider
`timescale 1ns/100ps

module div_unit #(
	parameter int XLEN = mdu_pkg::XLEN
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue,
	input  mdu_pkg::unit_req_t req,
	input  logic               grant,
	output logic               done,
	output logic               ready,
	output mdu_pkg::wb_t       result
);

	localparam int CW = $clog2(XLEN);
	localparam int HX = mdu_pkg::HXLEN;

	mdu_pkg::div_state_e state;
	mdu_pkg::div_op_e    req_op;
	logic                req_signed;
	logic [XLEN-1:0]     abs1;
	logic [XLEN-1:0]     abs2;
	logic                zero_div;
	logic                overflow;

	logic [XLEN-1:0]     quo;       // Dividend shifting out, quotient shifting in.
	logic [XLEN-1:0]     rem;
	logic [XLEN-1:0]     dvs;
	logic [XLEN-1:0]     dividend;
	logic [CW-1:0]       cnt;
	logic                op_rem;
	logic                op_word;
	logic                neg_q;
	logic                neg_r;
	logic                is_zero;
	logic                is_ovf;
	mdu_pkg::tag_t       tag;
	logic [XLEN-1:0]     res;

	logic [XLEN:0]       rem_sh;
	logic [XLEN+1:0]     diff;
	logic [XLEN-1:0]     q_fix;
	logic [XLEN-1:0]     r_fix;
	logic [XLEN-1:0]     pick;

	assign req_op     = mdu_pkg::div_op_e'(req.op);
	assign req_signed = (req_op == mdu_pkg::DIV_Q_S) || (req_op == mdu_pkg::DIV_R_S);
	assign abs1 = (req_signed && req.src1[XLEN-1]) ? -req.src1 : req.src1;
	assign abs2 = (req_signed && req.src2[XLEN-1]) ? -req.src2 : req.src2;

	assign zero_div = req.word ? (req.src2[HX-1:0] == '0) : (req.src2 == '0);
	assign overflow = req_signed && (req.word ?
		(req.src1[HX-1:0] == {1'b1, {(HX-1){1'b0}}} && &req.src2[HX-1:0]) :
		(req.src1 == {1'b1, {(XLEN-1){1'b0}}} && &req.src2));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= mdu_pkg::IDLE;
		end else begin
			case (state)
				mdu_pkg::IDLE: if (issue) state <= (zero_div || overflow) ? mdu_pkg::FIX : mdu_pkg::RUN;
				mdu_pkg::RUN:  if (cnt == '0) state <= mdu_pkg::FIX;
				mdu_pkg::FIX:  state <= mdu_pkg::DONE;
				default:       if (grant) state <= mdu_pkg::IDLE;
			endcase
		end
	end

	// Restoring step. Borrow out of the wide difference means no subtract.
	assign rem_sh = {rem, quo[XLEN-1]};
	assign diff   = {1'b0, rem_sh} - {2'b00, dvs};

	always_ff @(posedge clk) begin
		case (state)
			mdu_pkg::IDLE: if (issue) begin
				quo      <= abs1;
				rem      <= '0;
				dvs      <= abs2;
				dividend <= req.src1;
				cnt      <= CW'(XLEN - 1);
				op_rem   <= (req_op == mdu_pkg::DIV_R_S) || (req_op == mdu_pkg::DIV_R_U);
				op_word  <= req.word;
				tag      <= req.tag;
				neg_q    <= req_signed && (req.src1[XLEN-1] ^ req.src2[XLEN-1]);
				neg_r    <= req_signed && req.src1[XLEN-1];
				is_zero  <= zero_div;
				is_ovf   <= overflow;
			end
			mdu_pkg::RUN: begin
				quo <= {quo[XLEN-2:0], !diff[XLEN+1]};
				rem <= diff[XLEN+1] ? rem_sh[XLEN-1:0] : diff[XLEN-1:0];
				cnt <= cnt - 1'b1;
			end
			mdu_pkg::FIX: res <= op_word ? {{HX{pick[HX-1]}}, pick[HX-1:0]} : pick;
			default: ;
		endcase
	end

	// Sign restore, then the special cases override.
	always_comb begin
		q_fix = neg_q ? -quo : quo;
		r_fix = neg_r ? -rem : rem;
		if (is_zero) begin
			q_fix = '1;
			r_fix = dividend;
		end else if (is_ovf) begin
			q_fix = dividend;
			r_fix = '0;
		end
		pick = op_rem ? r_fix : q_fix;
	end

	assign done        = (state == mdu_pkg::DONE);
	assign ready       = (state == mdu_pkg::IDLE);
	assign result.tag  = tag;
	assign result.data = res;

	a_issue_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> state == mdu_pkg::IDLE);

	a_grant_in_done: assert property (@(posedge clk) disable iff (!rst_n)
		grant |-> state == mdu_pkg::DONE);

endmodule

// ==== source/wb_arbiter.sv ====
// Write-back arbiter
`timescale 1ns/100ps

module wb_arbiter (
	input  logic         mul_done,
	input  mdu_pkg::wb_t mul_result,
	input  logic         div_done,
	input  mdu_pkg::wb_t div_result,
	output logic         mul_stall,
	output logic         div_grant,
	output logic         wb_valid,
	output mdu_pkg::wb_t wb
);

	// Divider has fixed priority on the shared port.
	assign div_grant = div_done;

	// Multiplier holds its pipeline while it loses.
	assign mul_stall = mul_done && div_done;

	assign wb_valid = mul_done || div_done;
	assign wb       = div_done ? div_result : mul_result;  // One result per cycle.

endmodule

// ==== source/mdu.sv ====
// Multiply/divide unit
`timescale 1ns/100ps

module mdu #(
	parameter int XLEN = mdu_pkg::XLEN
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              issue,
	input  mdu_pkg::mdu_req_t req,
	output logic              mul_ready,
	output logic              div_ready,
	output logic              wb_valid,
	output mdu_pkg::wb_t      wb
);

	logic               mul_issue;
	logic               div_issue;
	mdu_pkg::unit_req_t unit_req;
	logic               mul_done;
	logic               div_done;
	mdu_pkg::wb_t       mul_result;
	mdu_pkg::wb_t       div_result;
	logic               mul_stall;
	logic               div_grant;

	assign mul_ready = !mul_stall;

	mdu_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.issue     (issue),
		.req       (req),
		.mul_ready (mul_ready),
		.div_ready (div_ready),
		.mul_issue (mul_issue),
		.div_issue (div_issue),
		.unit_req  (unit_req)
	);

	mul_unit #(.XLEN(XLEN)) u_mul (
		.clk    (clk),
		.rst_n  (rst_n),
		.issue  (mul_issue),
		.req    (unit_req),
		.stall  (mul_stall),
		.done   (mul_done),
		.result (mul_result)
	);

	div_unit #(.XLEN(XLEN)) u_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.issue  (div_issue),
		.req    (unit_req),
		.grant  (div_grant),
		.done   (div_done),
		.ready  (div_ready),
		.result (div_result)
	);

	wb_arbiter u_arbiter (
		.mul_done   (mul_done),
		.mul_result (mul_result),
		.div_done   (div_done),
		.div_result (div_result),
		.mul_stall  (mul_stall),
		.div_grant  (div_grant),
		.wb_valid   (wb_valid),
		.wb         (wb)
	);

endmodule

// ==== sim/mdu_tb.sv ====
// Multiply/divide unit testbench
`timescale 1ns/100ps

module mdu_tb;

	localparam int XLEN = 64;

	logic              clk;
	logic              rst_n;
	logic              issue;
	mdu_pkg::mdu_req_t req;
	logic              mul_ready;
	logic              div_ready;
	logic              wb_valid;
	mdu_pkg::wb_t      wb;

	integer            seed;
	mdu_pkg::xlen_t    expected [32];  // Modelled result per tag.
	logic [31:0]       pending;
	mdu_pkg::tag_t     next_tag;
	string             test_name;
	int                test_issued;
	int                test_results;
	int                test_errors;
	int                total_checks;
	int                total_errors;
	int                stall_cycles;

	mdu #(.XLEN(XLEN)) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.issue     (issue),
		.req       (req),
		.mul_ready (mul_ready),
		.div_ready (div_ready),
		.wb_valid  (wb_valid),
		.wb        (wb)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Expected value from the M-extension rules.
	function automatic mdu_pkg::xlen_t model_result(input logic [3:0] op,
			input mdu_pkg::xlen_t a, input mdu_pkg::xlen_t b);
		logic signed [127:0] prod_s;
		logic [127:0]        prod_u;
		logic signed [63:0]  sa;
		logic signed [63:0]  sb;
		logic signed [31:0]  wa;
		logic signed [31:0]  wd;
		logic [31:0]         w;
		logic                zero;
		logic                ovf;
		sa   = a;
		sb   = b;
		wa   = a[31:0];
		wd   = b[31:0];
		w    = '0;
		zero = op[3] ? (b[31:0] == 32'd0) : (b == 64'd0);
		ovf  = op[3] ? (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) :
			(a == 64'h8000_0000_0000_0000 && b == '1);
		model_result = '0;
		case (op)
			mdu_pkg::OP_MUL: model_result = a * b;
			mdu_pkg::OP_MULH: begin
				prod_s = sa * sb;
				model_result = prod_s[127:64];
			end
			mdu_pkg::OP_MULHSU: begin
				prod_s = sa * $signed({1'b0, b});
				model_result = prod_s[127:64];
			end
			mdu_pkg::OP_MULHU: begin
				prod_u = a * b;
				model_result = prod_u[127:64];
			end
			mdu_pkg::OP_DIV:
				if (zero) model_result = '1;
				else if (ovf) model_result = a;
				else model_result = sa / sb;
			mdu_pkg::OP_DIVU: model_result = zero ? '1 : a / b;
			mdu_pkg::OP_REM:
				if (zero) model_result = a;
				else if (ovf) model_result = '0;
				else model_result = sa % sb;
			mdu_pkg::OP_REMU: model_result = zero ? a : a % b;
			mdu_pkg::OP_MULW: w = a[31:0] * b[31:0];
			mdu_pkg::OP_DIVW:
				if (zero) w = '1;
				else if (ovf) w = a[31:0];
				else w = wa / wd;
			mdu_pkg::OP_DIVUW: w = zero ? 32'hffff_ffff : a[31:0] / b[31:0];
			mdu_pkg::OP_REMW:
				if (zero) w = a[31:0];
				else if (ovf) w = '0;
				else w = wa % wd;
			mdu_pkg::OP_REMUW: w = zero ? a[31:0] : a[31:0] % b[31:0];
			default: model_result = '0;
		endcase
		if (op[3])
			model_result = {{32{w[31]}}, w};  // Word forms sign-extend bit 31.
	endfunction

	function automatic mdu_pkg::xlen_t rand64();
		rand64 = {$random(seed), $random(seed)};
	endfunction

	function automatic int rand_below(input int n);
		rand_below = $unsigned($random(seed)) % n;
	endfunction

	function automatic mdu_pkg::xlen_t edge_val(input int i);
		case (i)
			0:       edge_val = 64'd0;
			1:       edge_val = '1;
			2:       edge_val = 64'h8000_0000_0000_0000;
			default: edge_val = 64'h7fff_ffff_ffff_ffff;
		endcase
	endfunction

	// 0..3 full-width multiplies, 4 is MULW.
	function automatic logic [3:0] mul_code(input int k);
		mul_code = (k < 4) ? {2'b00, k[1:0]} : 4'b1000;
	endfunction

	// 0..3 full-width divides, 4..7 the word forms.
	function automatic logic [3:0] div_code(input int k);
		div_code = {k[2], 1'b1, k[1:0]};
	endfunction

	task automatic check_value(input string name, input mdu_pkg::xlen_t exp_val,
			input mdu_pkg::xlen_t act_val);
		total_checks++;
		if (act_val !== exp_val) begin
			$display("MISMATCH %s: expected %h, actual %h", name, exp_val, act_val);
			test_errors++;
			total_errors++;
		end
	endtask

	// Waits for a free tag and a ready unit, then strobes issue for one cycle.
	task automatic send_op(input logic [3:0] op, input mdu_pkg::xlen_t a,
			input mdu_pkg::xlen_t b);
		int waited;
		waited = 0;
		while ((pending[next_tag] || !(op[2] ? div_ready : mul_ready)) && waited < 200) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (pending[next_tag] || !(op[2] ? div_ready : mul_ready)) begin
			$display("Timeout in %s: tag %0d or its unit never became free", test_name, next_tag);
			test_errors++;
			total_errors++;
			return;
		end
		req.src1   = a;
		req.src2   = b;
		req.word   = op[3];
		req.funct3 = op[2:0];
		req.tag    = next_tag;
		expected[next_tag] = model_result(op, a, b);
		pending[next_tag]  = 1'b1;
		issue = 1'b1;
		test_issued++;
		next_tag = next_tag + 1'b1;
		@(posedge clk);
		#2;
		issue = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic start_test(input string name);
		@(posedge clk);
		#2;
		test_name    = name;
		test_issued  = 0;
		test_results = 0;
		test_errors  = 0;
	endtask

	task automatic end_test();
		int waited;
		waited = 0;
		while (pending != '0 && waited < 300) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (pending != '0) begin
			$display("Timeout in %s: %0d results never came back", test_name, $countones(pending));
			test_errors++;
			total_errors++;
		end
		check_value({test_name, " result count"}, 64'(test_issued), 64'(test_results));
		$display("%s: %0d issued, %0d results, %0d errors", test_name, test_issued,
			test_results, test_errors);
	endtask

	// Scoreboard. Outputs are settled by the falling edge.
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (!mul_ready)
				stall_cycles++;  // Multiplier lost a collision.
			if (pending[wb.tag]) begin
				check_value($sformatf("%s tag %0d", test_name, wb.tag), expected[wb.tag], wb.data);
				pending[wb.tag] = 1'b0;
				test_results++;
			end else begin
				$display("ERROR %s: result for tag %0d arrived with nothing outstanding",
					test_name, wb.tag);
				test_errors++;
				total_errors++;
			end
		end
	end

	initial begin
		int             i;
		int             j;
		int             k;
		int             r;
		mdu_pkg::xlen_t a;
		mdu_pkg::xlen_t b;
		seed         = 99;
		rst_n        = 1'b0;
		issue        = 1'b0;
		req          = '0;
		pending      = '0;
		next_tag     = '0;
		total_checks = 0;
		total_errors = 0;
		stall_cycles = 0;
		test_name    = "reset";
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		start_test("idle");
		for (i = 0; i < 20; i++) begin
			@(negedge clk);
			check_value("idle", 64'd3, {61'd0, wb_valid, mul_ready, div_ready});
		end
		end_test();

		start_test("mul_edge");
		for (k = 0; k < 5; k++)
			for (i = 0; i < 4; i++)
				for (j = 0; j < 4; j++)
					send_op(mul_code(k), edge_val(i), edge_val(j));
		end_test();

		start_test("mul_random");
		for (i = 0; i < 200; i++)
			send_op(mul_code(rand_below(5)), rand64(), rand64());
		end_test();

		start_test("div_random");
		for (i = 0; i < 40; i++) begin
			a = rand64();
			b = rand64() >> rand_below(64);  // Spread the quotient sizes.
			if (b == '0)
				b = 64'd1;
			send_op(div_code(rand_below(4)), a, b);
		end
		end_test();

		start_test("div_special");
		for (k = 0; k < 8; k++) begin
			send_op(div_code(k), rand64(), {rand64() & {32'hffff_ffff, 32'd0}} & {64{k[2]}});
			a = rand64();
			b = rand64();
			if (k[2]) begin
				a[31:0] = 32'h8000_0000;  // Word overflow under garbage upper halves.
				b[31:0] = 32'hffff_ffff;
			end else begin
				a = 64'h8000_0000_0000_0000;
				b = '1;
			end
			send_op(div_code(k), a, b);
		end
		end_test();

		start_test("word_garbage");
		for (i = 0; i < 60; i++) begin
			k = rand_below(5);
			a = rand64();
			b = rand64();
			b[31:0] = b[31:0] >> rand_below(32);
			if (b[31:0] == 32'd0)
				b[0] = 1'b1;
			send_op((k == 0) ? mul_code(4) : div_code(3 + k), a, b);
		end
		end_test();

		start_test("mixed");
		stall_cycles = 0;
		for (r = 0; r < 6; r++) begin
			b = rand64() >> rand_below(64);
			if (b == '0)
				b = 64'd3;
			send_op(div_code(rand_below(8)), rand64(), b);
			idle_cycles(40 + 3 * r);
			for (i = 0; i < 30; i++)
				send_op(mul_code(rand_below(5)), rand64(), rand64());
		end
		check_value("mixed collision seen", 64'd1, 64'(stall_cycles > 0));
		end_test();

		$display("Checks: %0d, errors: %0d", total_checks, total_errors);
		if (total_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== mdu.f ====
source/mdu_pkg.sv
source/mdu_decode.sv
source/mul_unit.sv
source/div_unit.sv
source/wb_arbiter.sv
source/mdu.sv
sim/mdu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the mdu testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mdu_tb -f mdu.f -o mdu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mdu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0
